// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_wh_top
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= TEST OK

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== build.f ====
+incdir+hw
hw/gat_pkg.sv
hw/feature_bram.sv
hw/wh_mac_array.sv
hw/wh_sequencer.sv
hw/wh_top.sv
testbench/tb_wh_top.sv

// ==== hw/feature_bram.sv ====
`timescale 1ns/1ps
`default_nettype none

module feature_bram #(
  parameter int width = 12,
  parameter int depth = 320
) (
  input  logic                     clk,
  input  logic                     reset,
  input  logic [width-1:0]         din,
  input  logic [$clog2(depth)-1:0] addra,
  input  logic                     ena,
  input  logic                     wea,
  input  logic [$clog2(depth)-1:0] addrb,
  output logic [width-1:0]         dout
);

  logic [width-1:0] mem [depth];

  always_ff @(posedge clk) begin
    if (ena && wea) begin
      mem[addra] <= din;
    end
  end

  // Registered read with one cycle of latency
  always_ff @(posedge clk) begin
    if (reset) begin
      dout <= '0;
    end else begin
      dout <= mem[addrb];
    end
  end

  a_write_in_range: assert property (@(posedge clk) disable iff (reset)
    (ena && wea) |-> (int'(addra) < depth));

endmodule

`default_nettype wire

// ==== hw/gat_cfg.svh ====
`ifndef GAT_CFG_SVH
`define GAT_CFG_SVH

// Data widths
`define GAT_DATA_WIDTH      8
`define GAT_WH_DATA_WIDTH   12
`define GAT_ACC_WIDTH       20

// W is NUM_FEATURE_IN rows by NUM_FEATURE_OUT columns
`define GAT_NUM_FEATURE_IN  16
`define GAT_NUM_FEATURE_OUT 7

// Graph sizes
`define GAT_NUM_SUBGRAPHS   5
`define GAT_MAX_NODES       9
`define GAT_TOTAL_NODES     20

// Memory depths
`define GAT_H_DEPTH         (`GAT_TOTAL_NODES * `GAT_NUM_FEATURE_IN)
`define GAT_WH_DEPTH        128

`endif

// ==== hw/gat_pkg.sv ====
`default_nettype none

`include "gat_cfg.svh"

package gat_pkg;

  localparam int col_idx_w  = $clog2(`GAT_NUM_FEATURE_IN);
  localparam int num_node_w = $clog2(`GAT_MAX_NODES + 1);

  typedef logic signed [`GAT_DATA_WIDTH-1:0]    data_t;
  typedef logic [col_idx_w-1:0]                 col_idx_t;
  // Column index in the upper bits, value in the lower bits
  typedef logic [col_idx_w+`GAT_DATA_WIDTH-1:0] h_entry_t;
  typedef logic signed [`GAT_ACC_WIDTH-1:0]     acc_t;
  typedef logic signed [`GAT_WH_DATA_WIDTH-1:0] wh_elem_t;
  typedef logic [num_node_w-1:0]                num_node_t;
  // Flag, node count, then the elements with element 0 lowest
  typedef logic [1+num_node_w+`GAT_WH_DATA_WIDTH*`GAT_NUM_FEATURE_OUT-1:0] wh_word_t;
  typedef logic [$clog2(`GAT_H_DEPTH)-1:0]       h_addr_t;
  typedef logic [$clog2(`GAT_NUM_SUBGRAPHS)-1:0] sg_addr_t;
  typedef logic [$clog2(`GAT_WH_DEPTH)-1:0]      wh_addr_t;

  typedef enum logic [2:0] {
    st_idle,
    st_cnt_req,
    st_cnt_wait,
    st_row,
    st_drain
  } seq_state_t;

endpackage

`default_nettype wire

// ==== hw/wh_mac_array.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "gat_cfg.svh"

module wh_mac_array
  import gat_pkg::*;
(
  input  logic                                                     clk,
  input  logic                                                     reset,
  input  data_t [`GAT_NUM_FEATURE_OUT-1:0][`GAT_NUM_FEATURE_IN-1:0] wgt,
  input  logic                                                     in_valid,
  input  logic                                                     first,
  input  logic                                                     last,
  input  h_entry_t                                                 h_entry,
  input  wh_addr_t                                                 tag_node,
  input  num_node_t                                                tag_num,
  input  logic                                                     tag_flag,
  output logic                                                     out_valid,
  output wh_elem_t [`GAT_NUM_FEATURE_OUT-1:0]                      out_elems,
  output wh_addr_t                                                 out_node,
  output num_node_t                                                out_num,
  output logic                                                     out_flag
);

  localparam acc_t elem_max = (acc_t'(1) <<< (`GAT_WH_DATA_WIDTH - 1)) - acc_t'(1);
  localparam acc_t elem_min = -(acc_t'(1) <<< (`GAT_WH_DATA_WIDTH - 1));

  col_idx_t col;
  data_t    value;
  acc_t     acc      [`GAT_NUM_FEATURE_OUT];
  acc_t     sum_next [`GAT_NUM_FEATURE_OUT];

  function automatic wh_elem_t saturate(input acc_t sum);
    if (sum > elem_max) begin
      return wh_elem_t'(elem_max);
    end
    if (sum < elem_min) begin
      return wh_elem_t'(elem_min);
    end
    return wh_elem_t'(sum);
  endfunction

  assign col   = h_entry[$bits(h_entry_t)-1 -: col_idx_w];
  assign value = data_t'(h_entry[`GAT_DATA_WIDTH-1:0]);

  // Column index picks the weight row for every lane
  always_comb begin
    for (int o = 0; o < `GAT_NUM_FEATURE_OUT; o++) begin
      sum_next[o] = acc_t'(value) * acc_t'(data_t'(wgt[o][col]));
      if (!first) begin
        sum_next[o] = acc[o] + sum_next[o];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= in_valid && last;
    end
  end

  always_ff @(posedge clk) begin
    for (int o = 0; o < `GAT_NUM_FEATURE_OUT; o++) begin
      if (in_valid) begin
        acc[o] <= sum_next[o];
      end
      if (in_valid && last) begin
        out_elems[o] <= saturate(sum_next[o]);
      end
    end
    if (in_valid && last) begin
      out_node <= tag_node;
      out_num  <= tag_num;
      out_flag <= tag_flag;
    end
  end

  a_marks_need_valid: assert property (@(posedge clk) disable iff (reset)
    (first || last) |-> in_valid);

endmodule

`default_nettype wire

// ==== hw/wh_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "gat_cfg.svh"

module wh_sequencer
  import gat_pkg::*;
(
  input  logic                                clk,
  input  logic                                reset,
  input  logic                                spmm_vld,
  output logic                                spmm_rdy,
  output sg_addr_t                            num_node_addrb,
  input  num_node_t                           num_node_dout,
  output h_addr_t                             h_addrb,
  output logic                                mac_in_valid,
  output logic                                mac_first,
  output logic                                mac_last,
  output wh_addr_t                            tag_node,
  output num_node_t                           tag_num,
  output logic                                tag_flag,
  input  logic                                mac_out_valid,
  input  wh_addr_t                            mac_node,
  input  num_node_t                           mac_num,
  input  logic                                mac_flag,
  input  wh_elem_t [`GAT_NUM_FEATURE_OUT-1:0] mac_elems,
  output logic                                wh_bram_ena,
  output wh_addr_t                            wh_bram_addra,
  output wh_word_t                            wh_bram_din
);

  localparam col_idx_t col_last = col_idx_t'(`GAT_NUM_FEATURE_IN - 1);
  localparam sg_addr_t sg_last  = sg_addr_t'(`GAT_NUM_SUBGRAPHS - 1);

  seq_state_t state;
  sg_addr_t   sg_idx;
  num_node_t  node_cnt;
  num_node_t  node_in_sg;
  col_idx_t   col;
  h_addr_t    h_addr;
  wh_addr_t   node_glb;
  wh_addr_t   wr_cnt;
  logic       issue;
  logic       row_end;
  logic       sg_end;

  assign spmm_rdy       = (state == st_idle);
  assign num_node_addrb = sg_idx;
  assign h_addrb        = h_addr;
  assign issue          = (state == st_row);
  assign row_end        = issue && (col == col_last);
  assign sg_end         = row_end && (node_in_sg == node_cnt - num_node_t'(1));

  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= st_idle;
      sg_idx     <= '0;
      node_cnt   <= '0;
      node_in_sg <= '0;
      col        <= '0;
      h_addr     <= '0;
      node_glb   <= '0;
      wr_cnt     <= '0;
    end else begin
      if (wh_bram_ena) begin
        wr_cnt <= wr_cnt + wh_addr_t'(1);
      end
      case (state)
        st_idle: begin
          if (spmm_vld && spmm_rdy) begin
            state    <= st_cnt_req;
            sg_idx   <= '0;
            h_addr   <= '0;
            node_glb <= '0;
            wr_cnt   <= '0;
          end
        end
        st_cnt_req: state <= st_cnt_wait;
        st_cnt_wait: begin
          node_cnt   <= num_node_dout;
          node_in_sg <= '0;
          col        <= '0;
          state      <= st_row;
        end
        st_row: begin
          // H rows are dense, so the address just keeps counting
          h_addr <= h_addr + h_addr_t'(1);
          col    <= row_end ? '0 : col + col_idx_t'(1);
          if (row_end) begin
            node_glb   <= node_glb + wh_addr_t'(1);
            node_in_sg <= node_in_sg + num_node_t'(1);
          end
          if (sg_end) begin
            if (sg_idx == sg_last) begin
              state <= st_drain;
            end else begin
              sg_idx <= sg_idx + sg_addr_t'(1);
              state  <= st_cnt_req;
            end
          end
        end
        st_drain: begin
          if (wh_bram_ena && (wr_cnt == node_glb - wh_addr_t'(1))) begin
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // Marks trail the address by one cycle to line up with the H read data
  always_ff @(posedge clk) begin
    if (reset) begin
      mac_in_valid <= 1'b0;
      mac_first    <= 1'b0;
      mac_last     <= 1'b0;
      wh_bram_ena  <= 1'b0;
    end else begin
      mac_in_valid <= issue;
      mac_first    <= issue && (col == '0);
      mac_last     <= row_end;
      wh_bram_ena  <= mac_out_valid;
    end
  end

  always_ff @(posedge clk) begin
    tag_node <= node_glb;
    tag_num  <= node_cnt;
    tag_flag <= (node_in_sg == '0);
    if (mac_out_valid) begin
      wh_bram_addra <= mac_node;
      wh_bram_din   <= {mac_flag, mac_num, mac_elems};
    end
  end

  a_count_in_range: assert property (@(posedge clk) disable iff (reset)
    (state == st_cnt_wait) |->
      (num_node_dout >= num_node_t'(1) && num_node_dout <= num_node_t'(`GAT_MAX_NODES)));

  a_addr_in_range: assert property (@(posedge clk) disable iff (reset)
    wh_bram_ena |-> (wh_bram_addra < wh_addr_t'(`GAT_TOTAL_NODES)));

  // Last entry of a row reaches the WH port two cycles after the array sees it
  a_row_to_write: assert property (@(posedge clk) disable iff (reset)
    (mac_in_valid && mac_last) |-> ##2 wh_bram_ena);

endmodule

`default_nettype wire

// ==== hw/wh_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "gat_cfg.svh"

module wh_top
  import gat_pkg::*;
(
  input  logic                                                     clk,
  input  logic                                                     reset,
  input  logic                                                     spmm_vld,
  output logic                                                     spmm_rdy,
  input  data_t [`GAT_NUM_FEATURE_OUT-1:0][`GAT_NUM_FEATURE_IN-1:0] wgt,
  input  h_entry_t                                                 h_data_bram_din,
  input  h_addr_t                                                  h_data_bram_addra,
  input  logic                                                     h_data_bram_ena,
  input  logic                                                     h_data_bram_wea,
  input  num_node_t                                                num_node_bram_din,
  input  sg_addr_t                                                 num_node_bram_addra,
  input  logic                                                     num_node_bram_ena,
  input  logic                                                     num_node_bram_wea,
  output logic                                                     wh_bram_ena,
  output wh_addr_t                                                 wh_bram_addra,
  output wh_word_t                                                 wh_bram_din
);

  h_entry_t                            h_data_bram_dout;
  h_addr_t                             h_data_bram_addrb;
  num_node_t                           num_node_bram_dout;
  sg_addr_t                            num_node_bram_addrb;
  logic                                mac_in_valid;
  logic                                mac_first;
  logic                                mac_last;
  wh_addr_t                            tag_node;
  num_node_t                           tag_num;
  logic                                tag_flag;
  logic                                mac_out_valid;
  wh_elem_t [`GAT_NUM_FEATURE_OUT-1:0] mac_elems;
  wh_addr_t                            mac_node;
  num_node_t                           mac_num;
  logic                                mac_flag;

  feature_bram #(
    .width ($bits(h_entry_t)),
    .depth (`GAT_H_DEPTH)
  ) u_h_data_bram (
    .clk   (clk),
    .reset (reset),
    .din   (h_data_bram_din),
    .addra (h_data_bram_addra),
    .ena   (h_data_bram_ena),
    .wea   (h_data_bram_wea),
    .addrb (h_data_bram_addrb),
    .dout  (h_data_bram_dout)
  );

  feature_bram #(
    .width ($bits(num_node_t)),
    .depth (`GAT_NUM_SUBGRAPHS)
  ) u_num_node_bram (
    .clk   (clk),
    .reset (reset),
    .din   (num_node_bram_din),
    .addra (num_node_bram_addra),
    .ena   (num_node_bram_ena),
    .wea   (num_node_bram_wea),
    .addrb (num_node_bram_addrb),
    .dout  (num_node_bram_dout)
  );

  wh_sequencer u_wh_sequencer (
    .clk            (clk),
    .reset          (reset),
    .spmm_vld       (spmm_vld),
    .spmm_rdy       (spmm_rdy),
    .num_node_addrb (num_node_bram_addrb),
    .num_node_dout  (num_node_bram_dout),
    .h_addrb        (h_data_bram_addrb),
    .mac_in_valid   (mac_in_valid),
    .mac_first      (mac_first),
    .mac_last       (mac_last),
    .tag_node       (tag_node),
    .tag_num        (tag_num),
    .tag_flag       (tag_flag),
    .mac_out_valid  (mac_out_valid),
    .mac_node       (mac_node),
    .mac_num        (mac_num),
    .mac_flag       (mac_flag),
    .mac_elems      (mac_elems),
    .wh_bram_ena    (wh_bram_ena),
    .wh_bram_addra  (wh_bram_addra),
    .wh_bram_din    (wh_bram_din)
  );

  wh_mac_array u_wh_mac_array (
    .clk       (clk),
    .reset     (reset),
    .wgt       (wgt),
    .in_valid  (mac_in_valid),
    .first     (mac_first),
    .last      (mac_last),
    .h_entry   (h_data_bram_dout),
    .tag_node  (tag_node),
    .tag_num   (tag_num),
    .tag_flag  (tag_flag),
    .out_valid (mac_out_valid),
    .out_elems (mac_elems),
    .out_node  (mac_node),
    .out_num   (mac_num),
    .out_flag  (mac_flag)
  );

endmodule

`default_nettype wire

// ==== testbench/tb_wh_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "gat_cfg.svh"

module tb_wh_top
  import gat_pkg::*;
();

  localparam int fin             = `GAT_NUM_FEATURE_IN;
  localparam int fout            = `GAT_NUM_FEATURE_OUT;
  localparam int n_sg            = `GAT_NUM_SUBGRAPHS;
  localparam int n_total         = `GAT_TOTAL_NODES;
  localparam int elem_bits       = `GAT_WH_DATA_WIDTH * fout;
  localparam int elem_max        = (1 << (`GAT_WH_DATA_WIDTH - 1)) - 1;
  localparam int elem_min        = -(1 << (`GAT_WH_DATA_WIDTH - 1));
  localparam int pass_cycles     = n_total * fin + n_sg * 2 + 10;
  localparam int num_passes      = 6;
  localparam int watchdog_cycles = num_passes * pass_cycles * 4;

  logic                      clk;
  logic                      reset;
  logic                      spmm_vld;
  logic                      spmm_rdy;
  data_t [fout-1:0][fin-1:0] wgt;
  h_entry_t                  h_din;
  h_addr_t                   h_addra;
  logic                      h_ena;
  logic                      h_wea;
  num_node_t                 nn_din;
  sg_addr_t                  nn_addra;
  logic                      nn_ena;
  logic                      nn_wea;
  logic                      wh_bram_ena;
  wh_addr_t                  wh_bram_addra;
  wh_word_t                  wh_bram_din;

  // Images of what was loaded into the DUT
  h_entry_t h_img [`GAT_H_DEPTH];
  int       nn_img [n_sg];
  int       w_img [fout][fin];

  integer seed = 32'hedb6bf8a;
  string  test_name;
  int     check_errors = 0;
  int     flow_errors = 0;
  int     errs_at_start;
  int     tests_run = 0;
  int     tests_failed = 0;
  int     checks = 0;
  int     write_total = 0;
  int     pass_base = 0;
  int     passes_done = 0;
  logic   rdy_pending = 1'b0;

  wh_top i_dut (
    .clk                 (clk),
    .reset               (reset),
    .spmm_vld            (spmm_vld),
    .spmm_rdy            (spmm_rdy),
    .wgt                 (wgt),
    .h_data_bram_din     (h_din),
    .h_data_bram_addra   (h_addra),
    .h_data_bram_ena     (h_ena),
    .h_data_bram_wea     (h_wea),
    .num_node_bram_din   (nn_din),
    .num_node_bram_addra (nn_addra),
    .num_node_bram_ena   (nn_ena),
    .num_node_bram_wea   (nn_wea),
    .wh_bram_ena         (wh_bram_ena),
    .wh_bram_addra       (wh_bram_addra),
    .wh_bram_din         (wh_bram_din)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic h_entry_t make_entry(input int col, input int value);
    return {col_idx_t'(col), data_t'(value)};
  endfunction

  // Expected WH word for one global node index
  function automatic wh_word_t wh_ref(input int node);
    wh_word_t word;
    int       first;
    int       sg;
    int       sum;
    int       val;
    int       col;
    first = 0;
    sg = 0;
    while (sg < n_sg - 1 && node >= first + nn_img[sg]) begin
      first += nn_img[sg];
      sg++;
    end
    word = '0;
    for (int o = 0; o < fout; o++) begin
      sum = 0;
      for (int i = 0; i < fin; i++) begin
        val = int'(data_t'(h_img[node * fin + i][`GAT_DATA_WIDTH-1:0]));
        col = int'(h_img[node * fin + i][$bits(h_entry_t)-1 -: col_idx_w]);
        sum += val * w_img[o][col];
      end
      if (sum > elem_max) sum = elem_max;
      if (sum < elem_min) sum = elem_min;
      word[o*`GAT_WH_DATA_WIDTH +: `GAT_WH_DATA_WIDTH] = sum[`GAT_WH_DATA_WIDTH-1:0];
    end
    word[elem_bits +: $bits(num_node_t)] = nn_img[sg][$bits(num_node_t)-1:0];
    word[$bits(wh_word_t)-1] = (node == first);
    return word;
  endfunction

  task automatic set_counts(input int c0, input int c1, input int c2, input int c3,
                            input int c4);
    nn_img = '{c0, c1, c2, c3, c4};
  endtask

  // Counts between 1 and MAX_NODES that add up to the node total
  task automatic random_counts();
    int left;
    int k;
    for (k = 0; k < n_sg; k++) nn_img[k] = 1;
    left = n_total - n_sg;
    while (left > 0) begin
      k = int'($unsigned($random(seed)) % n_sg);
      if (nn_img[k] < `GAT_MAX_NODES) begin
        nn_img[k]++;
        left--;
      end
    end
  endtask

  task automatic fill_pattern();
    for (int o = 0; o < fout; o++)
      for (int r = 0; r < fin; r++) w_img[o][r] = r + 1;
    for (int n = 0; n < n_total; n++)
      for (int j = 0; j < fin; j++) h_img[n * fin + j] = make_entry(j, j);
  endtask

  task automatic fill_random(input bit extreme);
    int r;
    for (int o = 0; o < fout; o++) begin
      for (int i = 0; i < fin; i++) begin
        r = $random(seed);
        w_img[o][i] = int'($signed(r[7:0]));
        // Full-scale weights on rows 0 to 3 drive both clamps
        if (extreme && i < 4) w_img[o][i] = (o % 2 == 0) ? 127 : -128;
      end
    end
    for (int n = 0; n < n_total; n++) begin
      for (int j = 0; j < fin; j++) begin
        r = $random(seed);
        if (extreme && n % 5 == 2) begin
          h_img[n * fin + j] = make_entry(j % 4, (n % 10 == 2) ? 127 : -128);
        end else begin
          h_img[n * fin + j] = h_entry_t'(r[11:0]);
        end
      end
    end
  endtask

  task automatic load_memories();
    for (int a = 0; a < `GAT_H_DEPTH; a++) begin
      @(posedge clk);
      h_ena   <= 1'b1;
      h_wea   <= 1'b1;
      h_addra <= h_addr_t'(a);
      h_din   <= h_img[a];
    end
    for (int s = 0; s < n_sg; s++) begin
      @(posedge clk);
      h_ena    <= 1'b0;
      h_wea    <= 1'b0;
      nn_ena   <= 1'b1;
      nn_wea   <= 1'b1;
      nn_addra <= sg_addr_t'(s);
      nn_din   <= num_node_t'(nn_img[s]);
    end
    @(posedge clk);
    nn_ena <= 1'b0;
    nn_wea <= 1'b0;
    for (int o = 0; o < fout; o++)
      for (int i = 0; i < fin; i++) wgt[o][i] <= data_t'(w_img[o][i]);
  endtask

  task automatic run_pass(input bit hold_vld);
    int  cycles;
    int  done_before;
    bit  started;
    @(negedge clk);
    pass_base = write_total;
    done_before = passes_done;
    assert (spmm_rdy) else begin
      $display("spmm_rdy was low before the start in %s", test_name);
      flow_errors++;
    end
    @(posedge clk);
    spmm_vld <= 1'b1;
    cycles = 0;
    started = 1'b0;
    while (!started && cycles < 10) begin
      @(negedge clk);
      started = !spmm_rdy;
      cycles++;
    end
    if (!started) begin
      $display("Start handshake was not accepted in %s", test_name);
      flow_errors++;
      @(posedge clk);
      spmm_vld <= 1'b0;
      return;
    end
    if (!hold_vld) begin
      @(posedge clk);
      spmm_vld <= 1'b0;
    end
    cycles = 0;
    while (passes_done == done_before && cycles < 2 * pass_cycles) begin
      @(negedge clk);
      // Release a held start on the edge that ends the final write
      if (spmm_vld && wh_bram_ena && write_total - pass_base == n_total - 1) begin
        @(posedge clk);
        spmm_vld <= 1'b0;
      end
      cycles++;
    end
    if (passes_done == done_before) begin
      $display("Pass did not finish in %s, %0d of %0d writes seen", test_name,
               write_total - pass_base, n_total);
      flow_errors++;
      @(posedge clk);
      spmm_vld <= 1'b0;
    end
    repeat (12) @(posedge clk);
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    errs_at_start = check_errors + flow_errors;
  endtask

  task automatic end_test();
    int n;
    n = check_errors + flow_errors - errs_at_start;
    tests_run++;
    if (n != 0) tests_failed++;
    $display("%s: %s, %0d errors", test_name, (n == 0) ? "passed" : "failed", n);
  endtask

  always @(posedge clk) begin : check_writes
    int       idx;
    wh_word_t exp_word;
    if (rdy_pending) begin
      rdy_pending = 1'b0;
      assert (spmm_rdy) else begin
        $display("spmm_rdy was low in the cycle after the last write in %s", test_name);
        check_errors++;
      end
      passes_done++;
    end
    if (!reset && wh_bram_ena) begin
      idx = write_total - pass_base;
      write_total++;
      assert (idx < n_total) else begin
        $display("Extra write to address %0d after the pass ended in %s", wh_bram_addra,
                 test_name);
        check_errors++;
      end
      if (idx < n_total) begin
        exp_word = wh_ref(idx);
        checks++;
        assert (wh_bram_addra == wh_addr_t'(idx)) else begin
          $display("Mismatch in %s: address expected %0d actual %0d", test_name, idx,
                   wh_bram_addra);
          check_errors++;
        end
        assert (wh_bram_din[elem_bits-1:0] == exp_word[elem_bits-1:0]) else begin
          $display("Mismatch in %s: node %0d elements expected %h actual %h", test_name, idx,
                   exp_word[elem_bits-1:0], wh_bram_din[elem_bits-1:0]);
          check_errors++;
        end
        assert (wh_bram_din[$bits(wh_word_t)-1:elem_bits] ==
                exp_word[$bits(wh_word_t)-1:elem_bits]) else begin
          $display("Mismatch in %s: node %0d flag and count expected %h actual %h",
                   test_name, idx, exp_word[$bits(wh_word_t)-1:elem_bits],
                   wh_bram_din[$bits(wh_word_t)-1:elem_bits]);
          check_errors++;
        end
        if (idx == n_total - 1) rdy_pending = 1'b1;
      end
    end
  end

  initial begin : watchdog
    repeat (watchdog_cycles) @(posedge clk);
    $display("Run stopped by the watchdog after %0d cycles", watchdog_cycles);
    $display("TEST FAILED");
    $finish;
  end

  initial begin : main
    reset    = 1'b1;
    spmm_vld = 1'b0;
    wgt      = '0;
    h_din    = '0;
    h_addra  = '0;
    h_ena    = 1'b0;
    h_wea    = 1'b0;
    nn_din   = '0;
    nn_addra = '0;
    nn_ena   = 1'b0;
    nn_wea   = 1'b0;
    repeat (2) @(posedge clk);
    reset <= 1'b0;

    begin_test("ref_pattern");
    set_counts(3, 4, 2, 9, 2);
    fill_pattern();
    load_memories();
    run_pass(1'b0);
    end_test();

    begin_test("random_saturation");
    fill_random(1'b1);
    load_memories();
    run_pass(1'b0);
    end_test();

    begin_test("word_fields");
    set_counts(1, 9, 1, 8, 1);
    fill_random(1'b0);
    load_memories();
    run_pass(1'b0);
    end_test();

    begin_test("write_order");
    set_counts(4, 4, 4, 4, 4);
    fill_random(1'b0);
    load_memories();
    run_pass(1'b0);
    end_test();

    // Held start first, then a reload and a normal second pass
    begin_test("busy_start_second_pass");
    run_pass(1'b1);
    random_counts();
    fill_random(1'b1);
    load_memories();
    run_pass(1'b0);
    end_test();

    $display("%0d tests, %0d failed, %0d writes checked, %0d errors", tests_run,
             tests_failed, checks, check_errors + flow_errors);
    if (tests_failed == 0 && check_errors + flow_errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
